/* bd_bridge.f */
+incdir+design
design/bd_bridge_pkg.sv
design/routed_word_if.sv
design/bd_level_sync.sv
design/bd_rx_channel.sv
design/route_classifier.sv
design/bd_tx_channel.sv
design/bd_bridge.sv
tests/bd_bridge_checker.sv
tests/bd_bridge_tb.sv

/* Bender.yml */
package:
  name: bd_bridge

sources:
  - include_dirs:
      - design
    files:
      - design/bd_bridge_pkg.sv
      - design/routed_word_if.sv
      - design/bd_level_sync.sv
      - design/bd_rx_channel.sv
      - design/route_classifier.sv
      - design/bd_tx_channel.sv
      - design/bd_bridge.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/bd_bridge_checker.sv
      - tests/bd_bridge_tb.sv

/* tests/bd_bridge_tb.sv */
`default_nettype none

`include "bd_bridge_params.svh"

module bd_bridge_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_vectors    = 12;
  localparam int timeout_cycles = 40 * num_vectors + 20;

  logic                     clk;
  logic                     reset;
  logic [`BD_DATA_BITS-1:0] in_data;
  logic                     in_req;
  logic                     in_ack;
  logic [`BD_DATA_BITS-1:0] out_data;
  bd_bridge_pkg::route_e    out_route;
  logic                     out_req;
  logic                     out_ack;

  // leading bits of each word, their count, expected route, test name
  logic [`BD_DATA_BITS-1:0] vec_head [num_vectors] = '{
    34'b00, 34'b01, 34'b101, 34'b10000, 34'b10001, 34'b10010000000001,
    34'b100100000000000, 34'b100100000001100, 34'b11, 34'b10011, 34'b1001001, 34'b01
  };
  int vec_len [num_vectors] = '{2, 2, 3, 5, 5, 14, 15, 15, 2, 5, 7, 2};
  bd_bridge_pkg::route_e vec_route [num_vectors] = '{
    bd_bridge_pkg::route_down0, bd_bridge_pkg::route_down1, bd_bridge_pkg::route_tag,
    bd_bridge_pkg::route_reg0, bd_bridge_pkg::route_reg1, bd_bridge_pkg::route_cfg,
    bd_bridge_pkg::route_mem_rd, bd_bridge_pkg::route_mem_wr, bd_bridge_pkg::route_none,
    bd_bridge_pkg::route_none, bd_bridge_pkg::route_none, bd_bridge_pkg::route_down1
  };
  string vec_name [num_vectors] = '{
    "down0", "down1", "tag", "reg0", "reg1", "cfg", "mem_rd", "mem_wr",
    "none_11", "none_10011", "none_1001001", "down1_again"
  };

  logic [`BD_DATA_BITS-1:0] vec_word [num_vectors];
  logic [`BD_DATA_BITS-1:0] vec_expect [num_vectors];
  logic [31:0]              lfsr_state = 32'h3632_b826;
  int                       cycle_count = 0;

  bd_bridge dut0 (
    .clk(clk),
    .reset(reset),
    .in_data(in_data),
    .in_req(in_req),
    .in_ack(in_ack),
    .out_data(out_data),
    .out_route(out_route),
    .out_req(out_req),
    .out_ack(out_ack)
  );

  bind bd_bridge bd_bridge_checker checker0 (
    .clk(clk),
    .reset(reset),
    .in_req(in_req),
    .in_ack(in_ack),
    .out_data(out_data),
    .out_route(out_route),
    .out_req(out_req),
    .out_ack(out_ack)
  );

  // taps 32, 22, 2, 1
  function automatic logic [`BD_DATA_BITS-1:0] random_bits(input int count);
    logic [`BD_DATA_BITS-1:0] bits;
    logic                     fb;
    bits = '0;
    for (int k = 0; k < count; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits = {bits[`BD_DATA_BITS-2:0], fb};
    end
    return bits;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_route(input string name, input bd_bridge_pkg::route_e expected,
                             input bd_bridge_pkg::route_e actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %s: expected route %s (%0d), actual route %s (%0d)",
                          name, expected.name(), expected, actual.name(), actual));
    end
  endtask

  task automatic check_data(input string name, input logic [`BD_DATA_BITS-1:0] expected,
                            input logic [`BD_DATA_BITS-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %s: expected data %h, actual data %h", name, expected, actual));
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  // input channel partner, four-phase
  task automatic send_words();
    for (int i = 0; i < num_vectors; i++) begin
      in_data <= vec_word[i];
      @(posedge clk);
      in_req <= 1'b1;
      @(posedge clk);
      while (!in_ack) @(posedge clk);
      in_req <= 1'b0;
      @(posedge clk);
      while (in_ack) @(posedge clk);
    end
  endtask

  // output channel partner with random ack delays
  task automatic receive_words();
    int delay;
    for (int i = 0; i < num_vectors; i++) begin
      while (!out_req) @(posedge clk);
      check_route(vec_name[i], vec_route[i], out_route);
      check_data(vec_name[i], vec_expect[i], out_data);
      delay = int'(random_bits(3));
      repeat (delay) @(posedge clk);
      out_ack <= 1'b1;
      @(posedge clk);
      while (out_req) @(posedge clk);
      delay = int'(random_bits(3));
      repeat (delay) @(posedge clk);
      out_ack <= 1'b0;
      @(posedge clk);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      abort_run($sformatf("timeout: the run did not finish within %0d cycles",
                          timeout_cycles));
    end
  end

  initial begin
    logic [`BD_DATA_BITS-1:0] payload;
    reset   = 1'b1;
    in_req  = 1'b0;
    in_data = '0;
    out_ack = 1'b0;

    // prefix on top, random payload below it
    for (int i = 0; i < num_vectors; i++) begin
      payload     = random_bits(`BD_DATA_BITS - vec_len[i]);
      vec_word[i] = (vec_head[i] << (`BD_DATA_BITS - vec_len[i])) | payload;
      // a matched prefix leaves only the payload
      vec_expect[i] = (vec_route[i] == bd_bridge_pkg::route_none) ? vec_word[i] : payload;
    end

    repeat (2) @(posedge clk);
    reset <= 1'b0;

    repeat (3) begin
      @(posedge clk);
      check_level("in_ack idle after reset", 1'b0, in_ack);
      check_level("out_req idle after reset", 1'b0, out_req);
    end

    fork
      send_words();
      receive_words();
    join

    // nothing more may come out
    repeat (10) begin
      @(posedge clk);
      check_level("no extra word", 1'b0, out_req);
    end

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/bd_bridge_checker.sv */
`default_nettype none

`include "bd_bridge_params.svh"

module bd_bridge_checker (
  input logic                     clk,
  input logic                     reset,
  input logic                     in_req,
  input logic                     in_ack,
  input logic [`BD_DATA_BITS-1:0] out_data,
  input bd_bridge_pkg::route_e    out_route,
  input logic                     out_req,
  input logic                     out_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  // bundled data held while the request is up, setup cycle included
  out_bundle_stable: assert property (@(posedge clk) disable iff (reset)
    out_req |-> ($stable(out_data) && $stable(out_route)))
    else $error("out_data or out_route changed while out_req was high");

  // request stays up until acknowledged
  out_req_held: assert property (@(posedge clk) disable iff (reset)
    (out_req && !out_ack) |=> out_req)
    else $error("out_req fell before out_ack rose");

  in_ack_after_req: assert property (@(posedge clk) disable iff (reset)
    $rose(in_ack) |-> in_req)
    else $error("in_ack rose while in_req was low");

  idle_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> (!in_ack && !out_req))
    else $error("handshake outputs not low after reset");

endmodule

`default_nettype wire

/* design/bd_bridge.sv */
`default_nettype none

`include "bd_bridge_params.svh"

module bd_bridge (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`BD_DATA_BITS-1:0] in_data,
  input  logic                     in_req,
  output logic                     in_ack,
  output logic [`BD_DATA_BITS-1:0] out_data,
  output bd_bridge_pkg::route_e    out_route,
  output logic                     out_req,
  input  logic                     out_ack
);

  logic                     rx_valid;
  logic                     rx_ready;
  logic [`BD_DATA_BITS-1:0] rx_data;

  routed_word_if word_if ();

  bd_rx_channel rx0 (
    .clk(clk),
    .reset(reset),
    .in_data(in_data),
    .in_req(in_req),
    .in_ack(in_ack),
    .rx_valid(rx_valid),
    .rx_data(rx_data),
    .rx_ready(rx_ready)
  );

  route_classifier class0 (
    .clk(clk),
    .reset(reset),
    .rx_valid(rx_valid),
    .rx_data(rx_data),
    .rx_ready(rx_ready),
    .word(word_if.source)
  );

  bd_tx_channel tx0 (
    .clk(clk),
    .reset(reset),
    .word(word_if.sink),
    .out_data(out_data),
    .out_route(out_route),
    .out_req(out_req),
    .out_ack(out_ack)
  );

endmodule

`default_nettype wire

/* design/bd_tx_channel.sv */
`default_nettype none

`include "bd_bridge_params.svh"

module bd_tx_channel (
  input  logic                     clk,
  input  logic                     reset,
  routed_word_if.sink              word,
  output logic [`BD_DATA_BITS-1:0] out_data,
  output bd_bridge_pkg::route_e    out_route,
  output logic                     out_req,
  input  logic                     out_ack
);

  bd_bridge_pkg::tx_state_e state;
  logic                     ack_sync;

  bd_level_sync #(
    .stages(`BD_SYNC_STAGES)
  ) ack_sync0 (
    .clk(clk),
    .reset(reset),
    .level_in(out_ack),
    .level_out(ack_sync)
  );

  assign word.ready = (state == bd_bridge_pkg::tx_idle);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= bd_bridge_pkg::tx_idle;
      out_req   <= 1'b0;
      out_data  <= '0;
      out_route <= bd_bridge_pkg::route_none;
    end else begin
      case (state)
        bd_bridge_pkg::tx_idle: begin
          if (word.valid) begin
            out_data  <= word.data;
            out_route <= word.route;
            state     <= bd_bridge_pkg::tx_setup;
          end
        end
        bd_bridge_pkg::tx_setup: begin
          // data has settled for one cycle before req goes up
          out_req <= 1'b1;
          state   <= bd_bridge_pkg::tx_req;
        end
        bd_bridge_pkg::tx_req: begin
          if (ack_sync) begin
            out_req <= 1'b0;
            state   <= bd_bridge_pkg::tx_release;
          end
        end
        bd_bridge_pkg::tx_release: begin
          // wait for the far side to finish its return to zero
          if (!ack_sync) begin
            state <= bd_bridge_pkg::tx_idle;
          end
        end
        default: begin
          out_req <= 1'b0;
          state   <= bd_bridge_pkg::tx_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/route_classifier.sv */
`default_nettype none

`include "bd_bridge_params.svh"

module route_classifier (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     rx_valid,
  input  logic [`BD_DATA_BITS-1:0] rx_data,
  output logic                     rx_ready,
  routed_word_if.source            word
);

  logic [`BD_DATA_BITS-1:0] prefix_mask [`BD_NUM_ROUTES];
  logic [`BD_NUM_ROUTES-1:0] hit;
  logic [`BD_DATA_BITS-1:0] match_data;
  bd_bridge_pkg::route_e    match_route;

  // all rows compared at once
  for (genvar i = 0; i < `BD_NUM_ROUTES; i++) begin : g_rule
    assign prefix_mask[i] = ~({`BD_DATA_BITS{1'b1}} >> bd_bridge_pkg::route_table[i].len);
    assign hit[i] = ((rx_data ^ bd_bridge_pkg::route_table[i].prefix) & prefix_mask[i]) == '0;
  end

  // table is prefix-free, at most one hit
  always_comb begin
    match_route = bd_bridge_pkg::route_none;
    match_data  = rx_data;
    for (int i = 0; i < `BD_NUM_ROUTES; i++) begin
      if (hit[i]) begin
        match_route = bd_bridge_pkg::route_table[i].route;
        match_data  = rx_data & ~prefix_mask[i];
      end
    end
  end

  assign rx_ready = !word.valid || word.ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      word.valid <= 1'b0;
      word.data  <= '0;
      word.route <= bd_bridge_pkg::route_none;
    end else if (rx_ready) begin
      word.valid <= rx_valid;
      if (rx_valid) begin
        word.data  <= match_data;
        word.route <= match_route;
      end
    end
  end

endmodule

`default_nettype wire

/* design/bd_rx_channel.sv */
`default_nettype none

`include "bd_bridge_params.svh"

module bd_rx_channel (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`BD_DATA_BITS-1:0] in_data,
  input  logic                     in_req,
  output logic                     in_ack,
  output logic                     rx_valid,
  output logic [`BD_DATA_BITS-1:0] rx_data,
  input  logic                     rx_ready
);

  bd_bridge_pkg::rx_state_e state;
  logic                     req_sync;
  logic                     taken;

  bd_level_sync #(
    .stages(`BD_SYNC_STAGES)
  ) req_sync0 (
    .clk(clk),
    .reset(reset),
    .level_in(in_req),
    .level_out(req_sync)
  );

  // word already gone or leaving on this edge
  assign taken = !rx_valid || rx_ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= bd_bridge_pkg::rx_idle;
      rx_valid <= 1'b0;
      rx_data  <= '0;
    end else begin
      case (state)
        bd_bridge_pkg::rx_idle: begin
          // data has been stable since before req rose
          if (req_sync) begin
            rx_data  <= in_data;
            rx_valid <= 1'b1;
            state    <= bd_bridge_pkg::rx_hold;
          end
        end
        bd_bridge_pkg::rx_hold: begin
          if (rx_valid && rx_ready) begin
            rx_valid <= 1'b0;
          end
          // release ack once req is gone and the word moved on
          if (taken && !req_sync) begin
            state <= bd_bridge_pkg::rx_idle;
          end
        end
        default: begin
          state <= bd_bridge_pkg::rx_idle;
        end
      endcase
    end
  end

  // single state flop, so ack is glitch free
  assign in_ack = (state == bd_bridge_pkg::rx_hold);

endmodule

`default_nettype wire

/* design/bd_level_sync.sv */
`default_nettype none

`include "bd_bridge_params.svh"

module bd_level_sync #(
  parameter int stages = `BD_SYNC_STAGES
) (
  input  logic clk,
  input  logic reset,
  input  logic level_in,
  output logic level_out
);

  logic [stages-1:0] chain;

  // first flop may go metastable, later ones settle it
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      chain <= '0;
    end else begin
      chain[0] <= level_in;
      for (int i = 1; i < stages; i++) begin
        chain[i] <= chain[i-1];
      end
    end
  end

  assign level_out = chain[stages-1];

endmodule

`default_nettype wire

/* design/routed_word_if.sv */
`default_nettype none

`include "bd_bridge_params.svh"

interface routed_word_if;

  logic                     valid;
  logic                     ready;
  logic [`BD_DATA_BITS-1:0] data;
  bd_bridge_pkg::route_e    route;

  modport source (
    output valid, data, route,
    input  ready
  );

  modport sink (
    input  valid, data, route,
    output ready
  );

endinterface

`default_nettype wire

/* design/bd_bridge_pkg.sv */
`default_nettype none

`include "bd_bridge_params.svh"

package bd_bridge_pkg;

  typedef enum logic [3:0] {
    route_down0  = 4'd0,
    route_down1  = 4'd1,
    route_tag    = 4'd2,
    route_reg0   = 4'd3,
    route_reg1   = 4'd4,
    route_cfg    = 4'd5,
    route_mem_rd = 4'd6,
    route_mem_wr = 4'd7,
    route_none   = 4'd15
  } route_e;

  // prefix is left-aligned, len counts its leading bits
  typedef struct packed {
    logic [`BD_DATA_BITS-1:0] prefix;
    logic [3:0]               len;
    route_e                   route;
  } route_rule_t;

  // prefix-free, so one row at most can match
  localparam route_rule_t route_table [`BD_NUM_ROUTES] = '{
    '{prefix: {2'b00, {(`BD_DATA_BITS-2){1'b0}}}, len: 4'd2, route: route_down0},
    '{prefix: {2'b01, {(`BD_DATA_BITS-2){1'b0}}}, len: 4'd2, route: route_down1},
    '{prefix: {3'b101, {(`BD_DATA_BITS-3){1'b0}}}, len: 4'd3, route: route_tag},
    '{prefix: {5'b10000, {(`BD_DATA_BITS-5){1'b0}}}, len: 4'd5, route: route_reg0},
    '{prefix: {5'b10001, {(`BD_DATA_BITS-5){1'b0}}}, len: 4'd5, route: route_reg1},
    '{prefix: {14'b10010000000001, {(`BD_DATA_BITS-14){1'b0}}}, len: 4'd14,
      route: route_cfg},
    '{prefix: {15'b100100000000000, {(`BD_DATA_BITS-15){1'b0}}}, len: 4'd15,
      route: route_mem_rd},
    '{prefix: {15'b100100000001100, {(`BD_DATA_BITS-15){1'b0}}}, len: 4'd15,
      route: route_mem_wr}
  };

  typedef enum logic {
    rx_idle,
    rx_hold
  } rx_state_e;

  typedef enum logic [1:0] {
    tx_idle,
    tx_setup,
    tx_req,
    tx_release
  } tx_state_e;

endpackage

`default_nettype wire

/* design/bd_bridge_params.svh */
`ifndef BD_BRIDGE_PARAMS_SVH
`define BD_BRIDGE_PARAMS_SVH

// bundled word width
`define BD_DATA_BITS 34

// flops per handshake synchronizer
`define BD_SYNC_STAGES 2

// rows in the route table
`define BD_NUM_ROUTES 8

`endif
